//--- vlog.f
+incdir+common
common/spi_mem_pkg.sv
hdl/input_conditioner.sv
spi_fsm/spi_fsm.sv
hdl/shift_register.sv
hdl/data_memory.sv
hdl/spi_memory.sv
sim/spi_memory_tb.sv

//--- Makefile
# Verilator build and run for the spi byte memory

VERILATOR ?= verilator
TOP       ?= spi_memory_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Finished with no errors
VFLAGS    ?= --binary --timing --timescale 1ns/10ps

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/spi_memory_tb.sv
// spi byte memory testbench
// mode 0 spi master, reference memory model, miso compare and timeout

`timescale 1ns/10ps

`include "spi_mem_cfg.svh"

module spi_memory_tb;

	import spi_mem_pkg::*;

	localparam int sclk_half     = 8;    // system clocks per sclk half period
	localparam int n_random      = 40;   // random writes, then as many reads
	localparam int n_xfers       = 2 + 2 * n_random + 2;
	// cmd + data bits, two halves each, plus cs_n release and gap
	localparam int halves_per_xfer = 2 * (2 * `SPI_MEM_DATA_BITS) + 3;
	localparam int cycle_limit   =
		(n_xfers * halves_per_xfer * sclk_half) * 12 / 10 + 16;

	logic      peripheralClkEdge = 1'b0;
	logic      rst_n;
	logic      sclk;
	logic      cs_n;
	logic      mosi;
	spi_pins_t pins;
	logic      miso;
	logic      miso_oe;

	// reference model, only completed writes land here
	logic [`SPI_MEM_DATA_BITS-1:0] model_mem [2 ** `SPI_MEM_ADDR_BITS];
	logic [`SPI_MEM_ADDR_BITS-1:0] written_addr [$];   // safe read targets

	logic [15:0]                   lfsr = 16'd44503;
	logic                          read_phase = 1'b0;    // master in read data bits
	logic                          oe_must_low = 1'b1;   // miso_oe checked low per cycle
	logic [`SPI_MEM_DATA_BITS-1:0] read_expect = '0;
	logic [`SPI_MEM_DATA_BITS-1:0] rx_byte = '0;
	int                            rx_count = 0;
	int                            reads_checked = 0;
	int                            reads_expected = 0;
	int                            cycle_count = 0;
	fsm_state_t                    timeout_state;

	assign pins = '{sclk: sclk, cs_n: cs_n, mosi: mosi};

	spi_memory spi_memory_i (
		.peripheralClkEdge (peripheralClkEdge),
		.rst_n             (rst_n),
		.pins              (pins),
		.miso              (miso),
		.miso_oe           (miso_oe)
	);

	always #4 peripheralClkEdge = ~peripheralClkEdge;   // 8 ns period

	// --------------------
	// helpers
	// --------------------
	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	task automatic draw_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v    = {v[14:0], lfsr[0]};   // one step per bit
		end
	endtask

	// byte the memory must return for a read of addr
	function automatic logic [`SPI_MEM_DATA_BITS-1:0] expected_read(
		input logic [`SPI_MEM_ADDR_BITS-1:0] addr);
		return model_mem[addr];
	endfunction

	task automatic compare_value(input string name,
		input logic [`SPI_MEM_DATA_BITS-1:0] got,
		input logic [`SPI_MEM_DATA_BITS-1:0] want);
		if (got !== want) begin
			$display("[ERROR] %s got 0x%02h expected 0x%02h", name, got, want);
			$display("Finished with errors");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	// one sclk half period, pins move only on the falling system clock
	task automatic hold_half();
		repeat (sclk_half) begin
			@(negedge peripheralClkEdge);
			if (oe_must_low) begin
				compare_value("miso_oe", {7'd0, miso_oe}, 8'h00);
			end
		end
	endtask

	task automatic shift_bit(input logic b);
		mosi = b;   // set up while sclk is low
		hold_half();
		sclk = 1'b1;
		hold_half();
		sclk = 1'b0;
	endtask

	// --------------------
	// spi master
	// --------------------
	task automatic spi_transfer(input logic [`SPI_MEM_DATA_BITS-1:0] cmd,
		input logic [`SPI_MEM_DATA_BITS-1:0] data, input int data_bits,
		input logic is_read);
		cs_n = 1'b0;
		for (int i = `SPI_MEM_DATA_BITS - 1; i > 0; i--) begin
			shift_bit(cmd[i]);   // addr msb first
		end
		// rw bit last, a read turns oe on right after its rise
		mosi = cmd[0];
		hold_half();
		sclk = 1'b1;
		if (is_read) begin
			oe_must_low = 1'b0;
		end
		hold_half();
		sclk = 1'b0;
		if (is_read) begin
			read_phase = 1'b1;
		end
		for (int i = 0; i < data_bits; i++) begin
			shift_bit(data[`SPI_MEM_DATA_BITS-1-i]);
		end
		read_phase  = 1'b0;
		oe_must_low = 1'b1;   // oe drops well before the last fall
		hold_half();
		cs_n = 1'b1;
		hold_half();
		hold_half();   // idle gap between frames
	endtask

	task automatic spi_write(input logic [`SPI_MEM_ADDR_BITS-1:0] addr,
		input logic [`SPI_MEM_DATA_BITS-1:0] data);
		spi_transfer({addr, 1'b0}, data, `SPI_MEM_DATA_BITS, 1'b0);
		model_mem[addr] = data;
		written_addr.push_back(addr);
	endtask

	task automatic spi_read(input logic [`SPI_MEM_ADDR_BITS-1:0] addr);
		read_expect    = expected_read(addr);
		reads_expected = reads_expected + 1;
		spi_transfer({addr, 1'b1}, '0, `SPI_MEM_DATA_BITS, 1'b1);
	endtask

	// --------------------
	// miso compare
	// --------------------
	// master samples miso at its own rising sclk
	always @(posedge sclk) begin
		if (read_phase) begin
			compare_value("miso_oe", {7'd0, miso_oe}, 8'h01);
			rx_byte  = {rx_byte[`SPI_MEM_DATA_BITS-2:0], miso};
			rx_count = rx_count + 1;
			if (rx_count == `SPI_MEM_DATA_BITS) begin
				compare_value("miso_byte", rx_byte, read_expect);
				rx_count      = 0;
				reads_checked = reads_checked + 1;
			end
		end
	end

	// --------------------
	// timeout
	// --------------------
	always @(posedge peripheralClkEdge) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			timeout_state = spi_memory_i.spi_fsm_i.state;
			$display("timeout after %0d cycles, fsm stuck in %s",
				cycle_count, timeout_state.name());
			$display("Finished with errors");
			$fatal(1, "simulation did not finish in time");
		end
	end

	// --------------------
	// stimulus
	// --------------------
	initial begin : stimulus
		logic [15:0]                   v;
		logic [`SPI_MEM_ADDR_BITS-1:0] addr;
		logic [`SPI_MEM_ADDR_BITS-1:0] first_addr;
		logic [`SPI_MEM_DATA_BITS-1:0] data;
		int                            idx;

		rst_n = 1'b0;
		sclk  = 1'b0;
		cs_n  = 1'b1;   // bus idle
		mosi  = 1'b0;
		repeat (4) @(negedge peripheralClkEdge);
		rst_n = 1'b1;

		// outputs quiet after reset
		compare_value("miso_oe", {7'd0, miso_oe}, 8'h00);
		compare_value("miso", {7'd0, miso}, 8'h00);

		// single write then read back
		draw_bits(`SPI_MEM_ADDR_BITS, v);
		first_addr = v[`SPI_MEM_ADDR_BITS-1:0];
		draw_bits(`SPI_MEM_DATA_BITS, v);
		data = v[`SPI_MEM_DATA_BITS-1:0];
		spi_write(first_addr, data);
		spi_read(first_addr);

		// random writes
		for (int n = 0; n < n_random; n++) begin
			draw_bits(`SPI_MEM_ADDR_BITS, v);
			addr = v[`SPI_MEM_ADDR_BITS-1:0];
			draw_bits(`SPI_MEM_DATA_BITS, v);
			data = v[`SPI_MEM_DATA_BITS-1:0];
			spi_write(addr, data);
		end

		// random reads, only of written bytes
		for (int n = 0; n < n_random; n++) begin
			draw_bits(6, v);
			idx = int'(v[5:0]) % written_addr.size();
			spi_read(written_addr[idx]);
		end

		// write cut short after 4 data bits, byte must survive
		data = ~model_mem[first_addr];
		spi_transfer({first_addr, 1'b0}, data, 4, 1'b0);
		spi_read(first_addr);   // also shows a clean restart

		if (reads_checked != reads_expected) begin
			$display("only %0d of %0d reads were compared", reads_checked, reads_expected);
			$display("Finished with errors");
			$fatal(1, "read count mismatch");
		end else begin
			$display("Finished with no errors");
			$finish;
		end
	end

endmodule

//--- hdl/spi_memory.sv
// spi byte memory top
// ties the pin conditioner, transaction fsm, shift register and byte array

`timescale 1ns/10ps

`include "spi_mem_cfg.svh"

module spi_memory (
	input  logic                   peripheralClkEdge,
	input  logic                   rst_n,
	input  spi_mem_pkg::spi_pins_t pins,
	output logic                   miso,
	output logic                   miso_oe   // high only in the read data phase
);

	import spi_mem_pkg::*;

	spi_strobes_t                  strobes;    // conditioned pins
	fsm_ctrl_t                     ctrl;       // fsm pulses
	logic [`SPI_MEM_DATA_BITS-1:0] sr_word;    // shift reg parallel out
	logic [`SPI_MEM_DATA_BITS-1:0] mem_word;   // array read data

	// --------------------
	// pins in
	// --------------------
	input_conditioner input_conditioner_i (
		.peripheralClkEdge (peripheralClkEdge),
		.rst_n             (rst_n),
		.pins              (pins),
		.strobes           (strobes)
	);

	// --------------------
	// control
	// --------------------
	spi_fsm spi_fsm_i (
		.peripheralClkEdge (peripheralClkEdge),
		.rst_n             (rst_n),
		.strobes           (strobes),
		.rw                (sr_word[0]),   // read/write bit of the command byte
		.ctrl              (ctrl)
	);

	// --------------------
	// datapath
	// --------------------
	shift_register shift_register_i (
		.peripheralClkEdge (peripheralClkEdge),
		.rst_n             (rst_n),
		.strobes           (strobes),
		.load              (ctrl.sr_we),
		.load_data         (mem_word),
		.parallel          (sr_word),
		.miso              (miso)
	);

	data_memory data_memory_i (
		.peripheralClkEdge (peripheralClkEdge),
		.rst_n             (rst_n),
		.addr_we           (ctrl.addr_we),
		.dm_we             (ctrl.dm_we),
		.wdata             (sr_word),
		.rdata             (mem_word)
	);

	assign miso_oe = ctrl.miso_buff;

endmodule

//--- hdl/data_memory.sv
// spi data memory
// address latch plus byte array, combinational read from the latched address

`timescale 1ns/10ps

`include "spi_mem_cfg.svh"

module data_memory (
	input  logic                          peripheralClkEdge,
	input  logic                          rst_n,
	input  logic                          addr_we,   // latch address
	input  logic                          dm_we,     // write array
	input  logic [`SPI_MEM_DATA_BITS-1:0] wdata,     // shift reg word
	output logic [`SPI_MEM_DATA_BITS-1:0] rdata
);

	localparam int depth = 2 ** `SPI_MEM_ADDR_BITS;

	logic [`SPI_MEM_ADDR_BITS-1:0] addr_q;           // latched address
	logic [`SPI_MEM_DATA_BITS-1:0] mem_q [depth];    // byte array

	// --------------------
	// address latch
	// --------------------
	always_ff @(posedge peripheralClkEdge) begin
		if (!rst_n) begin
			addr_q <= '0;
		end else if (addr_we) begin
			// command byte is addr[6:0] then rw, so take the top bits
			addr_q <= wdata[`SPI_MEM_DATA_BITS-1 -: `SPI_MEM_ADDR_BITS];
		end
	end

	// array write, contents survive reset
	always_ff @(posedge peripheralClkEdge) begin
		if (dm_we) begin
			mem_q[addr_q] <= wdata;
		end
	end

	assign rdata = mem_q[addr_q];   // ready the cycle after addr_we

endmodule

//--- hdl/shift_register.sv
// spi shift register
// serial in on sclk rise, parallel load from memory, miso out on sclk fall

`timescale 1ns/10ps

`include "spi_mem_cfg.svh"

module shift_register (
	input  logic                          peripheralClkEdge,
	input  logic                          rst_n,
	input  spi_mem_pkg::spi_strobes_t     strobes,
	input  logic                          load,        // sr_we from the fsm
	input  logic [`SPI_MEM_DATA_BITS-1:0] load_data,   // memory read word
	output logic [`SPI_MEM_DATA_BITS-1:0] parallel,    // shifted in word
	output logic                          miso
);

	logic selected;   // frame active

	assign selected = ~strobes.cs_n;

	// --------------------
	// word register
	// --------------------
	always_ff @(posedge peripheralClkEdge) begin
		if (!rst_n) begin
			parallel <= '0;
		end else if (load) begin
			parallel <= load_data;   // load wins over a shift
		end else if (selected && strobes.sclk_rise) begin
			// msb first, new bit enters at the lsb
			parallel <= {parallel[`SPI_MEM_DATA_BITS-2:0], strobes.mosi};
		end
	end

	// --------------------
	// miso register
	// --------------------
	// updated on the fall so the master sees a settled bit at its next rise
	always_ff @(posedge peripheralClkEdge) begin
		if (!rst_n) begin
			miso <= 1'b0;
		end else if (selected && strobes.sclk_fall) begin
			miso <= parallel[`SPI_MEM_DATA_BITS-1];
		end
	end

endmodule

//--- spi_fsm/spi_fsm.sv
// spi transaction fsm
// counts sclk rises per byte and sequences address latch, load, write
// and miso enable for the byte memory

`timescale 1ns/10ps

`include "spi_mem_cfg.svh"

module spi_fsm (
	input  logic                      peripheralClkEdge,
	input  logic                      rst_n,
	input  spi_mem_pkg::spi_strobes_t strobes,
	input  logic                      rw,     // lsb of shift reg, 1 = read
	output spi_mem_pkg::fsm_ctrl_t    ctrl    // registered pulses + oe level
);

	import spi_mem_pkg::*;

	localparam logic [3:0] last_bit = 4'(`SPI_MEM_DATA_BITS - 1);

	fsm_state_t state;
	logic [3:0] bit_cnt;     // sclk rises seen in the current byte
	logic       counting;    // a byte is being shifted
	logic       byte_done;   // rise that completes the byte

	assign counting  = (state == s_get) || (state == s_read_shift) ||
		(state == s_write_shift);
	assign byte_done = strobes.sclk_rise && (bit_cnt == last_bit);

	// --------------------
	// bit counter
	// --------------------
	always_ff @(posedge peripheralClkEdge) begin
		if (!rst_n) begin
			bit_cnt <= '0;
		end else if (strobes.cs_n || !counting) begin
			bit_cnt <= '0;   // frame ended or not in a shift state
		end else if (strobes.sclk_rise) begin
			if (bit_cnt == last_bit) begin
				bit_cnt <= '0;   // ready for the next byte
			end else begin
				bit_cnt <= bit_cnt + 4'd1;
			end
		end
	end

	// --------------------
	// state + outputs
	// --------------------
	always_ff @(posedge peripheralClkEdge) begin
		if (!rst_n) begin
			state <= s_get;
			ctrl  <= '0;
		end else begin
			ctrl <= '0;   // pulses last one cycle

			if (strobes.cs_n) begin
				state <= s_get;   // deselect aborts whatever is running
			end else begin
				case (state)
					s_get: begin
						if (byte_done) begin
							state <= s_got;   // command byte now in shift reg
						end
					end

					s_got: begin
						// address bits are stable, sclk is still high here
						ctrl.addr_we <= 1'b1;
						if (rw) begin
							state <= s_read_load;
						end else begin
							state <= s_write_shift;
						end
					end

					s_read_load: begin
						ctrl.sr_we <= 1'b1;   // address latched by now
						state      <= s_read_shift;
					end

					s_read_shift: begin
						ctrl.miso_buff <= 1'b1;   // drive miso for all 8 rises
						if (byte_done) begin
							state <= s_done;
						end
					end

					s_write_shift: begin
						if (byte_done) begin
							state <= s_write_commit;
						end
					end

					s_write_commit: begin
						ctrl.dm_we <= 1'b1;   // data byte sits in shift reg
						state      <= s_done;
					end

					s_done: begin
						state <= s_done;   // no bursts, wait for cs_n
					end

					default: begin
						state <= s_get;   // unused encoding
					end
				endcase
			end
		end
	end

endmodule

//--- hdl/input_conditioner.sv
// input conditioner
// synchronizes sclk, cs_n and mosi and turns sclk into rise/fall strobes

`timescale 1ns/10ps

`include "spi_mem_cfg.svh"

module input_conditioner (
	input  logic                     peripheralClkEdge,
	input  logic                     rst_n,
	input  spi_mem_pkg::spi_pins_t   pins,      // asynchronous spi pins
	output spi_mem_pkg::spi_strobes_t strobes   // registered, 3 cycles behind pins
);

	import spi_mem_pkg::*;

	localparam int sync_last = `SPI_MEM_SYNC_STAGES - 1;

	// idle bus values so reset never fakes an edge or a frame
	localparam spi_pins_t pins_idle = '{sclk: 1'b0, cs_n: 1'b1, mosi: 1'b0};
	localparam spi_strobes_t strobes_idle =
		'{sclk_rise: 1'b0, sclk_fall: 1'b0, cs_n: 1'b1, mosi: 1'b0};

	spi_pins_t sync_q [`SPI_MEM_SYNC_STAGES];   // synchronizer chain
	logic      sclk_d;                           // previous synced sclk

	// --------------------
	// sync chain + edges
	// --------------------
	always_ff @(posedge peripheralClkEdge) begin
		if (!rst_n) begin
			for (int i = 0; i < `SPI_MEM_SYNC_STAGES; i++) begin
				sync_q[i] <= pins_idle;
			end
			sclk_d  <= 1'b0;
			strobes <= strobes_idle;
		end else begin
			sync_q[0] <= pins;   // first stage, may go metastable
			for (int i = 1; i < `SPI_MEM_SYNC_STAGES; i++) begin
				sync_q[i] <= sync_q[i-1];
			end

			sclk_d <= sync_q[sync_last].sclk;

			// edge detect on the last stage against its delayed copy
			strobes.sclk_rise <= sync_q[sync_last].sclk & ~sclk_d;
			strobes.sclk_fall <= ~sync_q[sync_last].sclk & sclk_d;
			strobes.cs_n      <= sync_q[sync_last].cs_n;   // kept aligned with the strobes
			strobes.mosi      <= sync_q[sync_last].mosi;
		end
	end

endmodule

//--- common/spi_mem_pkg.sv
// spi byte memory types
// pin bundle, conditioned strobes, fsm controls and fsm state encoding

package spi_mem_pkg;

	// --------------------
	// raw spi pins
	// --------------------
	typedef struct packed {
		logic sclk;   // mode 0 serial clock
		logic cs_n;   // frame select, active low
		logic mosi;   // master data out
	} spi_pins_t;

	// --------------------
	// conditioned pins
	// --------------------
	typedef struct packed {
		logic sclk_rise;   // one cycle, sclk went high
		logic sclk_fall;   // one cycle, sclk went low
		logic cs_n;        // synced level
		logic mosi;        // synced level
	} spi_strobes_t;

	// --------------------
	// fsm outputs
	// --------------------
	typedef struct packed {
		logic addr_we;     // latch address from shift register
		logic sr_we;       // parallel load of shift register
		logic dm_we;       // commit write byte
		logic miso_buff;   // miso output enable level
	} fsm_ctrl_t;

	// transaction states
	// reset value first
	typedef enum logic [2:0] {
		s_get          = 3'd0,   // shifting in command byte
		s_got          = 3'd1,   // command byte complete, decode rw
		s_read_load    = 3'd2,   // pull addressed byte into shift reg
		s_read_shift   = 3'd3,   // clocking data out on miso
		s_write_shift  = 3'd4,   // clocking data in on mosi
		s_write_commit = 3'd5,   // one cycle to write the array
		s_done         = 3'd6    // idle until cs_n goes high
	} fsm_state_t;

endpackage

//--- common/spi_mem_cfg.svh
// spi byte memory configuration
// widths and synchronizer depth shared by the rtl

`ifndef SPI_MEM_CFG_SVH
`define SPI_MEM_CFG_SVH

// --------------------
// memory geometry
// --------------------
`define SPI_MEM_ADDR_BITS 7    // address field of the command byte
`define SPI_MEM_DATA_BITS 8    // one memory word, also the shift register width

// --------------------
// pin conditioning
// --------------------
`define SPI_MEM_SYNC_STAGES 2  // flops per pin before edge detection

`endif
